/* design/display_pkg.sv */
`default_nettype none

package display_pkg;

    // stored image, one index per entry
    localparam int FB_WIDTH  = 16;
    localparam int FB_HEIGHT = 12;
    // screen pixels per stored pixel, each axis
    localparam int SCALE     = 2;
    localparam int SCALE_W   = $clog2(SCALE);
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDR_W = $clog2(FB_DEPTH);

    // data widths
    localparam int INDEX_W   = 4;
    localparam int DEPTH_W   = 12;
    localparam int CHANNEL_W = 4;

    // reduced raster, visible then front porch, sync, back porch
    localparam int H_VISIBLE = 32;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 4;
    localparam int H_BACK    = 2;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_VISIBLE = 24;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 1;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int COORD_W   = 6;

    // sync windows, half-open
    localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_VISIBLE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    // scaled image footprint on screen
    localparam int AREA_WIDTH  = FB_WIDTH * SCALE;
    localparam int AREA_HEIGHT = FB_HEIGHT * SCALE;

    // clear values, far plane and background index
    localparam logic [DEPTH_W-1:0] DEPTH_FAR   = {DEPTH_W{1'b1}};
    localparam logic [INDEX_W-1:0] INDEX_CLEAR = '0;

    typedef struct packed {
        logic                 valid;
        logic [FB_ADDR_W-1:0] addr;
        logic [INDEX_W-1:0]   index;
        logic [DEPTH_W-1:0]   depth;
    } pixel_write_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
        logic in_area;
    } beam_t;

    typedef struct packed {
        logic [CHANNEL_W-1:0] red;
        logic [CHANNEL_W-1:0] green;
        logic [CHANNEL_W-1:0] blue;
    } rgb_t;

    typedef struct packed {
        rgb_t color;
        logic hsync;
        logic vsync;
    } vga_out_t;

    // entry 0 is the background, kept away from black
    localparam rgb_t PALETTE [16] = '{
        12'h137, 12'hfff, 12'hf00, 12'h0f0,
        12'h00f, 12'hff0, 12'h0ff, 12'hf0f,
        12'h888, 12'hf80, 12'h8f0, 12'h08f,
        12'hf08, 12'h444, 12'hccc, 12'h210
    };

endpackage

`default_nettype wire

/* design/raster_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_timing import display_pkg::*; (
    input  logic               clk,
    input  logic               i_arst_n,
    output logic [COORD_W-1:0] o_x,
    output logic [COORD_W-1:0] o_y,
    output beam_t              o_beam,
    output logic               o_frame
);

    logic [COORD_W-1:0] h_cnt;
    logic [COORD_W-1:0] v_cnt;
    logic               line_end;
    logic               frame_end;
    beam_t              beam_next;

    // wrap points of the two counters
    assign line_end  = (h_cnt == COORD_W'(H_TOTAL - 1));
    assign frame_end = line_end && (v_cnt == COORD_W'(V_TOTAL - 1));

    // column and line counters
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
            // next line, or back to top after the last one
            v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // decode beam from the current position
    always_comb begin
        beam_next.hsync   = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
        beam_next.vsync   = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);
        beam_next.de      = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
        // scaled image may be smaller than the visible area
        beam_next.in_area = (h_cnt < AREA_WIDTH) && (v_cnt < AREA_HEIGHT);
    end

    // coordinates, beam and frame pulse leave registered together
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_x     <= '0;
            o_y     <= '0;
            o_beam  <= '0;
            o_frame <= 1'b0;
        end else begin
            o_x     <= h_cnt;
            o_y     <= v_cnt;
            o_beam  <= beam_next;
            // marks the last pixel of the frame
            o_frame <= frame_end;
        end
    end

endmodule

`default_nettype wire

/* design/pixel_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_buffer import display_pkg::*; #(
    parameter int               WIDTH       = INDEX_W,
    parameter logic [WIDTH-1:0] CLEAR_VALUE = '0
) (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic                 i_clear,
    input  logic                 i_we,
    input  logic [FB_ADDR_W-1:0] i_waddr,
    input  logic [WIDTH-1:0]     i_wdata,
    input  logic [FB_ADDR_W-1:0] i_raddr,
    output logic [WIDTH-1:0]     o_rdata,
    output logic                 o_ready
);

    logic [WIDTH-1:0]     mem [FB_DEPTH];
    logic                 clearing;
    logic [FB_ADDR_W-1:0] clr_addr;
    logic                 clr_last;

    assign clr_last = (clr_addr == FB_ADDR_W'(FB_DEPTH - 1));

    // sweep control, reset starts a sweep as well
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            clearing <= 1'b1;
            clr_addr <= '0;
        end else if (i_clear) begin
            // a new pulse restarts from address 0
            clearing <= 1'b1;
            clr_addr <= '0;
        end else if (clearing) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_last) begin
                clearing <= 1'b0;
            end
        end
    end

    // single write port, sweep has priority over i_we
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_addr] <= CLEAR_VALUE;
        end else if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, old data on a same-edge write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

    // low for the whole sweep
    assign o_ready = !clearing;

endmodule

`default_nettype wire

/* design/depth_write_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module depth_write_stage import display_pkg::*; (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  pixel_write_t         i_write,
    input  logic                 i_ready,
    input  logic [DEPTH_W-1:0]   i_stored_depth,
    output logic [FB_ADDR_W-1:0] o_depth_raddr,
    output logic                 o_we,
    output logic [FB_ADDR_W-1:0] o_waddr,
    output logic [INDEX_W-1:0]   o_index,
    output logic [DEPTH_W-1:0]   o_depth
);

    pixel_write_t         req;
    logic                 last_valid;
    logic [FB_ADDR_W-1:0] last_addr;
    logic [DEPTH_W-1:0]   last_depth;
    logic                 fwd_hit;
    logic [DEPTH_W-1:0]   ref_depth;

    // cycle 0, address goes straight to the depth read port
    assign o_depth_raddr = i_write.addr;

    // capture request, dropped while a sweep runs
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            req <= '0;
        end else begin
            req       <= i_write;
            req.valid <= i_write.valid && i_ready;
        end
    end

    // cycle 1, memory read missed the write that landed last edge
    assign fwd_hit   = last_valid && (last_addr == req.addr);
    assign ref_depth = fwd_hit ? last_depth : i_stored_depth;

    // strictly nearer wins, equal depth keeps the old pixel
    assign o_we    = req.valid && (req.depth < ref_depth);
    assign o_waddr = req.addr;
    assign o_index = req.index;
    assign o_depth = req.depth;

    // only the write of the previous edge needs forwarding
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            last_valid <= 1'b0;
        end else begin
            last_valid <= o_we;
        end
    end

    // address and depth of that write
    always_ff @(posedge clk) begin
        if (o_we) begin
            last_addr  <= req.addr;
            last_depth <= req.depth;
        end
    end

endmodule

`default_nettype wire

/* design/scanout_scaler.sv */
`timescale 1ns/1ps
`default_nettype none

module scanout_scaler import display_pkg::*; (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  beam_t                i_beam,
    input  logic                 i_frame,
    output logic [FB_ADDR_W-1:0] o_raddr,
    output beam_t                o_beam
);

    logic [SCALE_W-1:0]   x_scale;
    logic [SCALE_W-1:0]   y_scale;
    logic [FB_ADDR_W-1:0] fb_x;
    logic [FB_ADDR_W-1:0] row_base;
    logic                 x_rep_done;
    logic                 row_done;
    logic                 y_rep_done;
    beam_t                beam_d1;

    // end of one stored pixel, one stored row, one row repeat
    assign x_rep_done = (x_scale == SCALE_W'(SCALE - 1));
    assign row_done   = x_rep_done && (fb_x == FB_ADDR_W'(FB_WIDTH - 1));
    assign y_rep_done = (y_scale == SCALE_W'(SCALE - 1));

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_scale  <= '0;
            y_scale  <= '0;
            fb_x     <= '0;
            row_base <= '0;
            o_raddr  <= '0;
        end else if (i_frame) begin
            // frame pulse sits outside the area, restart at top left
            x_scale  <= '0;
            y_scale  <= '0;
            fb_x     <= '0;
            row_base <= '0;
        end else if (i_beam.in_area) begin
            // address for the pixel now on the beam
            o_raddr <= row_base + fb_x;
            if (!x_rep_done) begin
                x_scale <= x_scale + 1'b1;
            end else if (!row_done) begin
                x_scale <= '0;
                fb_x    <= fb_x + 1'b1;
            end else begin
                x_scale <= '0;
                fb_x    <= '0;
                // same row again, or move the base down one row
                if (y_rep_done) begin
                    y_scale  <= '0;
                    row_base <= row_base + FB_ADDR_W'(FB_WIDTH);
                end else begin
                    y_scale <= y_scale + 1'b1;
                end
            end
        end
    end

    // two stages, beam meets the read data at t+2
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            beam_d1 <= '0;
            o_beam  <= '0;
        end else begin
            beam_d1 <= i_beam;
            o_beam  <= beam_d1;
        end
    end

endmodule

`default_nettype wire

/* design/color_output.sv */
`timescale 1ns/1ps
`default_nettype none

module color_output import display_pkg::*; (
    input  logic               clk,
    input  logic               i_arst_n,
    input  logic [INDEX_W-1:0] i_index,
    input  beam_t              i_beam,
    output vga_out_t           o_vga
);

    rgb_t color_next;

    // palette lookup, black outside the image or the visible area
    always_comb begin
        if (i_beam.de && i_beam.in_area) begin
            color_next = PALETTE[i_index];
        end else begin
            color_next = '0;
        end
    end

    // colour and syncs leave on the same edge
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_vga <= '0;
        end else begin
            o_vga.color <= color_next;
            o_vga.hsync <= i_beam.hsync;
            o_vga.vsync <= i_beam.vsync;
        end
    end

endmodule

`default_nettype wire

/* design/display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module display_top import display_pkg::*; (
    input  logic         clk,
    input  logic         i_arst_n,
    input  pixel_write_t i_write,
    input  logic         i_clear,
    output logic         o_ready,
    output vga_out_t     o_vga
);

    // scanout side
    beam_t                raster_beam;
    logic                 raster_frame;
    logic [FB_ADDR_W-1:0] scan_raddr;
    beam_t                scan_beam;
    logic [INDEX_W-1:0]   scan_index;

    // write side
    logic [FB_ADDR_W-1:0] depth_raddr;
    logic [DEPTH_W-1:0]   stored_depth;
    logic                 wr_en;
    logic [FB_ADDR_W-1:0] wr_addr;
    logic [INDEX_W-1:0]   wr_index;
    logic [DEPTH_W-1:0]   wr_depth;
    logic                 fb_ready;
    logic                 db_ready;

    // both sweeps must be done
    assign o_ready = fb_ready && db_ready;

    raster_timing u_raster_timing (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .o_x      (),
        .o_y      (),
        .o_beam   (raster_beam),
        .o_frame  (raster_frame)
    );

    depth_write_stage u_depth_write_stage (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_write        (i_write),
        .i_ready        (o_ready),
        .i_stored_depth (stored_depth),
        .o_depth_raddr  (depth_raddr),
        .o_we           (wr_en),
        .o_waddr        (wr_addr),
        .o_index        (wr_index),
        .o_depth        (wr_depth)
    );

    // index store, read by scanout
    pixel_buffer #(
        .WIDTH       (INDEX_W),
        .CLEAR_VALUE (INDEX_CLEAR)
    ) u_frame_buffer (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_clear  (i_clear),
        .i_we     (wr_en),
        .i_waddr  (wr_addr),
        .i_wdata  (wr_index),
        .i_raddr  (scan_raddr),
        .o_rdata  (scan_index),
        .o_ready  (fb_ready)
    );

    // depth store, read by the write stage
    pixel_buffer #(
        .WIDTH       (DEPTH_W),
        .CLEAR_VALUE (DEPTH_FAR)
    ) u_depth_buffer (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_clear  (i_clear),
        .i_we     (wr_en),
        .i_waddr  (wr_addr),
        .i_wdata  (wr_depth),
        .i_raddr  (depth_raddr),
        .o_rdata  (stored_depth),
        .o_ready  (db_ready)
    );

    scanout_scaler u_scanout_scaler (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_beam   (raster_beam),
        .i_frame  (raster_frame),
        .o_raddr  (scan_raddr),
        .o_beam   (scan_beam)
    );

    color_output u_color_output (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_index  (scan_index),
        .i_beam   (scan_beam),
        .o_vga    (o_vga)
    );

endmodule

`default_nettype wire

/* bench/display_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module display_assert import display_pkg::*; (
    input logic     clk,
    input logic     i_arst_n,
    input logic     i_clear,
    input logic     i_ready,
    input vga_out_t i_vga,
    input beam_t    i_raster_beam
);

    int hs_run;
    int vs_run;
    // cycles since the last clear pulse, 0 when idle
    int clr_age;
    int assert_errors;

    initial assert_errors = 0;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hs_run  <= 0;
            vs_run  <= 0;
            clr_age <= 0;
        end else begin
            hs_run <= i_vga.hsync ? hs_run + 1 : 0;
            vs_run <= i_vga.vsync ? vs_run + 1 : 0;
            if (i_clear) begin
                clr_age <= 1;
            end else if (clr_age != 0 && clr_age < FB_DEPTH) begin
                clr_age <= clr_age + 1;
            end else begin
                clr_age <= 0;
            end
        end
    end

    hsync_width: assert property (@(posedge clk) disable iff (!i_arst_n)
        $fell(i_vga.hsync) |-> hs_run == H_SYNC)
    else begin
        assert_errors++;
        $error("hsync pulse of %0d cycles", hs_run);
    end

    // vsync spans whole lines
    vsync_width: assert property (@(posedge clk) disable iff (!i_arst_n)
        $fell(i_vga.vsync) |-> vs_run == V_SYNC * H_TOTAL)
    else begin
        assert_errors++;
        $error("vsync pulse of %0d cycles", vs_run);
    end

    // raster data enable reaches the pins three stages later
    blank_color: assert property (@(posedge clk) disable iff (!i_arst_n)
        !$past(i_raster_beam.de, 3) |-> i_vga.color == '0)
    else begin
        assert_errors++;
        $error("colour not zero outside data enable");
    end

    ready_low_in_sweep: assert property (@(posedge clk) disable iff (!i_arst_n)
        clr_age != 0 |-> !i_ready)
    else begin
        assert_errors++;
        $error("ready high %0d cycles after clear", clr_age);
    end

    ready_after_sweep: assert property (@(posedge clk) disable iff (!i_arst_n)
        (clr_age == FB_DEPTH && !i_clear) |=> i_ready)
    else begin
        assert_errors++;
        $error("ready still low after the sweep");
    end

endmodule

bind display_top display_assert u_display_assert (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_clear       (i_clear),
    .i_ready       (o_ready),
    .i_vga         (o_vga),
    .i_raster_beam (raster_beam)
);

`default_nettype wire

/* bench/display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module display_tb import display_pkg::*; ();

    localparam int CLK_HALF    = 50;
    localparam int DRIVE_DELAY = 5;
    localparam int TRACE_WORDS = 256;

    // trace command codes, four words per command
    localparam int CMD_WRITE      = 1;
    localparam int CMD_CLEAR      = 2;
    localparam int CMD_READY      = 3;
    localparam int CMD_READY_WAIT = 4;
    localparam int CMD_FRAME      = 5;
    localparam int CMD_EXPECT     = 6;
    localparam int CMD_RANDOM     = 7;
    localparam int CMD_TEST_END   = 8;
    localparam int CMD_END        = 15;

    logic         clk;
    logic         i_arst_n;
    pixel_write_t i_write;
    logic         i_clear;
    logic         o_ready;
    vga_out_t     o_vga;

    logic [15:0]        trace_mem [TRACE_WORDS];
    // reference model, nearest depth and its index per address
    logic [DEPTH_W-1:0] model_depth [FB_DEPTH];
    logic [INDEX_W-1:0] model_index [FB_DEPTH];
    // last frame seen on the VGA pins
    rgb_t               screen [V_VISIBLE][H_VISIBLE];

    int   errors = 0;
    int   test_errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   budget_cycles = 0;
    int   frames_started = 0;
    int   frames_done = 0;
    int   seed_value;
    int   col;
    int   line;
    logic h_locked;
    logic v_locked;
    logic prev_hs;
    logic prev_vs;

    display_top u_dut (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_write  (i_write),
        .i_clear  (i_clear),
        .o_ready  (o_ready),
        .o_vga    (o_vga)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    task automatic check_color(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s got %03h expected %03h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // both buffers back to far plane and background
    task automatic clear_model();
        for (int a = 0; a < FB_DEPTH; a++) begin
            model_depth[a] = DEPTH_FAR;
            model_index[a] = INDEX_CLEAR;
        end
    endtask

    task automatic drive_write(input logic [FB_ADDR_W-1:0] addr,
                               input logic [INDEX_W-1:0] index,
                               input logic [DEPTH_W-1:0] depth);
        pixel_write_t w;
        w.valid = 1'b1;
        w.addr  = addr;
        w.index = index;
        w.depth = depth;
        // dropped while not ready, kept only if strictly nearer
        if (o_ready && depth < model_depth[addr]) begin
            model_depth[addr] = depth;
            model_index[addr] = index;
        end
        i_write = w;
    endtask

    task automatic random_fill(input int count);
        logic [FB_ADDR_W-1:0] addr;
        for (int i = 0; i < count; i++) begin
            if (i != 0) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            // one in four hits the previous address on the next cycle
            if (i == 0 || $urandom % 4 != 0) begin
                addr = FB_ADDR_W'($urandom % FB_DEPTH);
            end
            drive_write(addr, INDEX_W'($urandom), DEPTH_W'($urandom));
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!o_ready && n < FB_DEPTH + 16) begin
            @(posedge clk);
            #DRIVE_DELAY;
            n++;
        end
        check_ready(o_ready, 1'b1, "ready after sweep");
    endtask

    // a whole frame that starts after the last write has landed
    task automatic wait_frame();
        int started;
        int done;
        repeat (8) @(posedge clk);
        started = frames_started;
        wait (frames_started > started);
        done = frames_done;
        wait (frames_done > done);
    endtask

    task automatic compare_frame();
        int   addr;
        rgb_t exp;
        for (int y = 0; y < V_VISIBLE; y++) begin
            for (int x = 0; x < H_VISIBLE; x++) begin
                if (x < FB_WIDTH * SCALE && y < FB_HEIGHT * SCALE) begin
                    addr = (y / SCALE) * FB_WIDTH + x / SCALE;
                    exp  = PALETTE[model_index[addr]];
                end else begin
                    exp = '0;
                end
                check_color(screen[y][x], exp, $sformatf("screen (%0d,%0d)", x, y));
            end
        end
    endtask

    // stored pixel covers a SCALE by SCALE block
    task automatic expect_block(input int x, input int y, input int index);
        rgb_t exp;
        exp = PALETTE[index];
        for (int dy = 0; dy < SCALE; dy++) begin
            for (int dx = 0; dx < SCALE; dx++) begin
                check_color(screen[y * SCALE + dy][x * SCALE + dx], exp,
                            $sformatf("block (%0d,%0d) index %0d", x, y, index));
            end
        end
    endtask

    task automatic end_test(input int id);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d passed", id);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", id, test_errors);
        end
        test_errors = 0;
    endtask

    // raster decoder, follows the syncs on the pins
    always @(negedge clk) begin
        if (!i_arst_n) begin
            h_locked = 1'b0;
            v_locked = 1'b0;
            prev_hs  = 1'b0;
            prev_vs  = 1'b0;
            col      = 0;
            line     = 0;
        end else begin
            // back porch follows the hsync fall
            if (prev_hs && !o_vga.hsync) begin
                col      = H_TOTAL - H_BACK;
                h_locked = 1'b1;
            end else begin
                col = (col == H_TOTAL - 1) ? 0 : col + 1;
                if (col == 0) begin
                    line = (line == V_TOTAL - 1) ? 0 : line + 1;
                end
            end
            if (prev_vs && !o_vga.vsync) begin
                line     = V_TOTAL - V_BACK;
                v_locked = 1'b1;
            end
            if (h_locked && v_locked) begin
                if (col < H_VISIBLE && line < V_VISIBLE) begin
                    screen[line][col] = o_vga.color;
                    if (col == 0 && line == 0) begin
                        frames_started++;
                    end
                    if (col == H_VISIBLE - 1 && line == V_VISIBLE - 1) begin
                        frames_done++;
                    end
                end else begin
                    check_color(o_vga.color, '0, "colour in blanking");
                end
            end
            prev_hs = o_vga.hsync;
            prev_vs = o_vga.vsync;
        end
    end

    // run limit from the trace length
    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", budget_cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        int          pc;
        int          frame_cmds;
        int          extra_cycles;
        int          sva_errors;
        logic [15:0] cmd;
        logic [15:0] a0;
        logic [15:0] a1;
        logic [15:0] a2;
        seed_value = $urandom(32'h15aa_ae2e);
        i_arst_n   = 1'b0;
        i_write    = '0;
        i_clear    = 1'b0;
        clear_model();
        $readmemh("bench/display_trace.txt", trace_mem);

        frame_cmds   = 0;
        extra_cycles = 0;
        for (pc = 0; pc < TRACE_WORDS && trace_mem[pc] !== 16'(CMD_END); pc += 4) begin
            if (trace_mem[pc] == 16'(CMD_FRAME)) begin
                frame_cmds++;
            end else if (trace_mem[pc] == 16'(CMD_READY_WAIT)) begin
                extra_cycles += FB_DEPTH;
            end else if (trace_mem[pc] == 16'(CMD_RANDOM)) begin
                extra_cycles += int'(trace_mem[pc + 1]);
            end
        end
        budget_cycles = 2 * (frame_cmds + 1) * V_TOTAL * H_TOTAL + extra_cycles + 1000;

        repeat (2) @(posedge clk);
        check_ready(o_ready, 1'b0, "ready in reset");
        check_color(o_vga.color, '0, "colour in reset");
        #DRIVE_DELAY;
        i_arst_n = 1'b1;

        pc = 0;
        while (pc < TRACE_WORDS && trace_mem[pc] !== 16'(CMD_END)) begin
            @(posedge clk);
            #DRIVE_DELAY;
            i_write = '0;
            i_clear = 1'b0;
            cmd     = trace_mem[pc];
            a0      = trace_mem[pc + 1];
            a1      = trace_mem[pc + 2];
            a2      = trace_mem[pc + 3];
            case (cmd)
                16'(CMD_WRITE): begin
                    drive_write(FB_ADDR_W'(a0), INDEX_W'(a1), DEPTH_W'(a2));
                end
                16'(CMD_CLEAR): begin
                    i_clear = 1'b1;
                    clear_model();
                end
                16'(CMD_READY):      check_ready(o_ready, a0[0], "ready level");
                16'(CMD_READY_WAIT): wait_ready();
                16'(CMD_FRAME): begin
                    wait_frame();
                    compare_frame();
                end
                16'(CMD_EXPECT):   expect_block(int'(a0), int'(a1), int'(a2));
                16'(CMD_RANDOM):   random_fill(int'(a0));
                16'(CMD_TEST_END): end_test(int'(a0));
                default: begin
                    $display("trace word %0d holds an unknown command %h", pc, cmd);
                    errors++;
                end
            endcase
            pc += 4;
        end

        sva_errors = u_dut.u_display_assert.assert_errors;
        $display("tests: %0d run, %0d failed, %0d check errors, %0d assertion errors",
                 tests_run, tests_failed, errors, sva_errors);
        if (tests_run > 0 && tests_failed == 0 && errors == 0 && sva_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/display_trace.txt */
// columns: cmd arg0 arg1 arg2, hex. 1 write addr index depth, 2 clear, 3 ready level,
// 4 wait ready, 5 wait frame, 6 expect x y index, 7 random writes, 8 end test, f end
3 0 0 0
4 0 0 0
5 0 0 0
8 1 0 0
1 23 5 100
5 0 0 0
6 3 2 5
8 2 0 0
1 23 2 200
5 0 0 0
6 3 2 5
1 23 9 080
5 0 0 0
6 3 2 9
8 3 0 0
1 40 3 050
1 40 4 060
1 41 6 300
1 41 7 100
1 42 1 200
1 42 8 100
1 42 c 150
5 0 0 0
6 0 4 3
6 1 4 7
6 2 4 8
8 4 0 0
2 0 0 0
3 0 0 0
1 50 5 001
1 23 1 000
4 0 0 0
5 0 0 0
6 3 2 0
6 0 5 0
8 5 0 0
7 c8 0 0
5 0 0 0
8 6 0 0
f 0 0 0

/* compile.f */
design/display_pkg.sv
design/raster_timing.sv
design/pixel_buffer.sv
design/depth_write_stage.sv
design/scanout_scaler.sv
design/color_output.sv
design/display_top.sv
bench/display_assert.sv
bench/display_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module display_tb --Mdir "$build_dir" -o display_sim -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/display_sim" +verilator+error+limit+1000 > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "sim passed" "$log_file"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
